// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    // ----------------------------------------
    // Port widths
    // ----------------------------------------
    localparam int w_key       = 8;           // Merged key vector
    localparam int w_led       = 8;           // TM1638 LEDs
    localparam int w_digit     = 8;           // TM1638 digits
    localparam int w_board_key = 4;           // Keys on the board
    localparam int w_board_led = 4;           // LEDs on the board
    localparam int w_sw        = 3;           // Fourth switch is the reset

    typedef logic [w_key - 1:0] key_t;
    typedef logic [w_led - 1:0] led_t;
    typedef logic [7:0]         seg_t;        // hgfedcba, bit 0 is segment a
    typedef logic [31:0]        count_t;
    typedef logic [7:0]         sio_byte_t;

    // ----------------------------------------
    // TM1638 protocol
    // ----------------------------------------
    localparam sio_byte_t cmd_write_auto = 8'h40;  // Write data, auto increment
    localparam sio_byte_t cmd_read_keys  = 8'h42;  // Read key scan
    localparam sio_byte_t cmd_addr_base  = 8'hC0;  // Display RAM address 0
    localparam sio_byte_t cmd_display_on = 8'h8F;  // Display on, full brightness

    localparam int sio_clk_khz = 1000;             // Serial clock rate

    // One refresh worth of display content
    typedef struct packed {
        seg_t [w_digit - 1:0] seg;            // Digit n in seg[n], digit 0 leftmost
        led_t                 led;            // One LED per digit
    } glyph_frame_t;

    // One serial byte and its strobe framing
    typedef struct packed {
        sio_byte_t data;
        logic      first;                     // Strobe falls before this byte
        logic      last;                      // Strobe rises after this byte
        logic      rd;                        // Byte comes from the device
    } sio_item_t;

    typedef enum logic [2:0] {
        idle,
        stb_setup,
        bit_low,
        bit_high,
        gap
    } sio_state_t;

endpackage

`default_nettype wire

// File: design/board_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_top #(
    parameter int clk_mhz = 125,
    parameter int tick_hz = 1
) (
    input  logic                                clk,
    input  logic                                reset,        // Fourth switch
    input  logic [board_pkg::w_board_key - 1:0] key,
    input  logic [board_pkg::w_sw - 1:0]        sw,
    output logic [board_pkg::w_board_led - 1:0] led,
    output logic                                sio_clk,
    output logic                                sio_stb,
    output logic                                sio_data_out,
    output logic                                sio_data_oe,
    input  logic                                sio_data_in
);

    import board_pkg::*;

    logic         tick;
    count_t       count;
    led_t         led_mask;
    key_t         key_tm;

    logic         glyph_valid;                        // Encoder to builder
    logic         glyph_ready;
    glyph_frame_t glyph_frame;

    logic         item_valid;                         // Builder to shifter
    logic         item_ready;
    sio_item_t    item;

    // ----------------------------------------
    // Lab design
    // ----------------------------------------
    slow_tick_gen #(.clk_mhz (clk_mhz), .tick_hz (tick_hz)) tick_gen_i (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    lab_top lab_i (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .key      (key),
        .key_tm   (key_tm),
        .sw       (sw),
        .count    (count),
        .led_mask (led_mask),
        .led      (led)
    );

    // ----------------------------------------
    // TM1638 pipeline
    // ----------------------------------------
    seg_glyph_encoder encoder_i (
        .clk       (clk),
        .reset     (reset),
        .count     (count),
        .led_mask  (led_mask),
        .out_valid (glyph_valid),
        .out_ready (glyph_ready),
        .out_frame (glyph_frame)
    );

    tm1638_frame_builder builder_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (glyph_valid),
        .in_ready  (glyph_ready),
        .in_frame  (glyph_frame),
        .out_valid (item_valid),
        .out_ready (item_ready),
        .out_item  (item)
    );

    tm1638_sio_shifter #(.clk_mhz (clk_mhz)) shifter_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (item_valid),
        .in_ready     (item_ready),
        .in_item      (item),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in),
        .key_tm       (key_tm)
    );

endmodule

`default_nettype wire

// File: design/lab_top.sv
`timescale 1ns/100ps
`default_nettype none

module lab_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                tick,
    input  logic [board_pkg::w_board_key - 1:0] key,
    input  board_pkg::key_t                     key_tm,
    input  logic [board_pkg::w_sw - 1:0]        sw,
    output board_pkg::count_t                   count,
    output board_pkg::led_t                     led_mask,
    output logic [board_pkg::w_board_led - 1:0] led
);

    import board_pkg::*;

    key_t keys_merged;                                // Board keys ORed with TM1638 keys

    // ----------------------------------------
    // Key merge
    // ----------------------------------------
    always_comb begin
        keys_merged = key_tm | {{(w_key - w_board_key){1'b0}}, key};
    end

    assign led_mask = keys_merged;                    // Pressed keys light TM1638 LEDs
    assign led      = keys_merged[w_board_led - 1:0]; // Low bits to the board

    // ----------------------------------------
    // Tick counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (tick && !sw[0])                      // Switch 0 freezes
            count <= count + 1'b1;
    end

endmodule

`default_nettype wire

// File: design/seg_glyph_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module seg_glyph_encoder (
    input  logic                    clk,
    input  logic                    reset,
    input  board_pkg::count_t       count,
    input  board_pkg::led_t         led_mask,
    output logic                    out_valid,
    input  logic                    out_ready,
    output board_pkg::glyph_frame_t out_frame
);

    import board_pkg::*;

    glyph_frame_t next_frame;

    // Hex digit to segments, dot always off
    function automatic seg_t hex_glyph(input logic [3:0] nib);
        case (nib)
            4'h0:    return 8'h3F;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5B;
            4'h3:    return 8'h4F;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6D;
            4'h6:    return 8'h7D;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7F;
            4'h9:    return 8'h6F;
            4'hA:    return 8'h77;
            4'hB:    return 8'h7C;
            4'hC:    return 8'h39;
            4'hD:    return 8'h5E;
            4'hE:    return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    // Digit 0 is leftmost, so it takes the top nibble
    always_comb begin
        for (int n = 0; n < w_digit; n++)
            next_frame.seg[n] = hex_glyph(count[4 * (w_digit - 1 - n) +: 4]);
        next_frame.led = led_mask;
    end

    // ----------------------------------------
    // Output register stage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (!out_valid)
            out_valid <= 1'b1;                        // Capture while empty
        else if (out_ready)
            out_valid <= 1'b0;                        // Accepted by the builder
    end

    always_ff @(posedge clk) begin
        if (!out_valid)
            out_frame <= next_frame;
    end

endmodule

`default_nettype wire

// File: design/slow_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module slow_tick_gen #(
    parameter int clk_mhz = 125,
    parameter int tick_hz = 1
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int divisor = clk_mhz * 1000000 / tick_hz;     // Cycles per tick
    localparam int w_cnt   = (divisor > 1) ? $clog2(divisor) : 1;

    logic [w_cnt - 1:0] cnt;                                  // Cycles left to next tick

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= w_cnt'(divisor - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= w_cnt'(divisor - 1);                      // Reload
            tick <= 1'b1;                                     // One-cycle strobe
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/tm1638_frame_builder.sv
`timescale 1ns/100ps
`default_nettype none

module tm1638_frame_builder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  board_pkg::glyph_frame_t in_frame,
    output logic                    out_valid,
    input  logic                    out_ready,
    output board_pkg::sio_item_t    out_item
);

    import board_pkg::*;

    glyph_frame_t frame;                              // Frame being sequenced
    logic         busy;
    logic [4:0]   idx;                                // Item index within the refresh
    logic [4:0]   data_idx;                           // Position in the 16 data bytes
    logic [2:0]   digit;

    assign in_ready  = !busy;
    assign out_valid = busy;
    assign data_idx  = idx - 5'd2;
    assign digit     = data_idx[3:1];

    // ----------------------------------------
    // Item selection
    // ----------------------------------------
    always_comb begin
        out_item = '0;
        if (idx == 5'd0) begin
            out_item.data  = cmd_write_auto;          // Group 1
            out_item.first = 1'b1;
            out_item.last  = 1'b1;
        end else if (idx == 5'd1) begin
            out_item.data  = cmd_addr_base;           // Group 2 opens
            out_item.first = 1'b1;
        end else if (idx <= 5'd17) begin
            if (data_idx[0])
                out_item.data = {7'd0, frame.led[digit]};  // LED byte
            else
                out_item.data = frame.seg[digit];          // Segment byte
            out_item.last = (idx == 5'd17);
        end else if (idx == 5'd18) begin
            out_item.data  = cmd_display_on;          // Group 3
            out_item.first = 1'b1;
            out_item.last  = 1'b1;
        end else if (idx == 5'd19) begin
            out_item.data  = cmd_read_keys;           // Group 4 opens
            out_item.first = 1'b1;
        end else begin
            out_item.rd   = 1'b1;                     // Four key bytes
            out_item.last = (idx == 5'd23);
        end
    end

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (!busy) begin
            if (in_valid) begin
                busy <= 1'b1;                         // New refresh
                idx  <= '0;
            end
        end else if (out_ready) begin
            if (idx == 5'd23)
                busy <= 1'b0;                         // Last read item sent
            else
                idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            frame <= in_frame;
    end

endmodule

`default_nettype wire

// File: design/tm1638_sio_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module tm1638_sio_shifter #(
    parameter int clk_mhz = 125
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  board_pkg::sio_item_t in_item,
    output logic                 sio_clk,
    output logic                 sio_stb,
    output logic                 sio_data_out,
    output logic                 sio_data_oe,
    input  logic                 sio_data_in,
    output board_pkg::key_t      key_tm
);

    import board_pkg::*;

    localparam int half_cycles = clk_mhz * 1000 / (2 * sio_clk_khz);  // Half serial period
    localparam int w_timer     = $clog2(half_cycles + 1);

    sio_state_t           state;
    sio_item_t            item;                       // Byte in flight
    logic [w_timer - 1:0] timer;
    logic                 timer_done;
    logic [2:0]           bit_cnt;
    logic [1:0]           rd_idx;                     // Read byte number
    sio_byte_t            rx_byte;
    key_t                 key_acc;
    key_t                 key_next;

    assign timer_done = (timer == '0);
    assign in_ready   = (state == idle);

    // Bit 0 is key i, bit 4 is key i+4
    always_comb begin
        key_next                  = key_acc;
        key_next[{1'b0, rd_idx}]  = rx_byte[0];
        key_next[{1'b1, rd_idx}]  = rx_byte[4];
    end

    // ----------------------------------------
    // Serial FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            timer        <= '0;
            bit_cnt      <= '0;
            rd_idx       <= '0;
            key_acc      <= '0;
            key_tm       <= '0;
            sio_clk      <= 1'b1;
            sio_stb      <= 1'b1;
            sio_data_out <= 1'b1;
            sio_data_oe  <= 1'b0;
        end else begin
            if (state != idle && !timer_done)
                timer <= timer - 1'b1;
            case (state)
                idle: begin
                    if (in_valid) begin
                        if (in_item.first)
                            sio_stb <= 1'b0;          // Open the group
                        timer   <= w_timer'(half_cycles - 1);
                        bit_cnt <= '0;
                        state   <= stb_setup;
                    end
                end
                stb_setup: begin
                    if (timer_done) begin
                        sio_clk      <= 1'b0;
                        sio_data_out <= item.rd | item.data[bit_cnt];  // LSB first
                        sio_data_oe  <= !item.rd;     // Release line for reads
                        timer        <= w_timer'(half_cycles - 1);
                        state        <= bit_low;
                    end
                end
                bit_low: begin
                    if (timer_done) begin
                        sio_clk <= 1'b1;              // Device samples here
                        timer   <= w_timer'(half_cycles - 1);
                        state   <= bit_high;
                    end
                end
                bit_high: begin
                    if (timer_done) begin
                        timer <= w_timer'(half_cycles - 1);
                        if (bit_cnt == 3'd7) begin
                            sio_data_oe <= 1'b0;
                            if (item.last)
                                sio_stb <= 1'b1;      // Close the group
                            if (item.rd) begin
                                key_acc <= key_next;
                                rd_idx  <= rd_idx + 1'b1;
                                if (rd_idx == 2'd3)
                                    key_tm <= key_next;  // All four read bytes in
                            end
                            state <= gap;
                        end else begin
                            bit_cnt      <= bit_cnt + 1'b1;
                            sio_clk      <= 1'b0;
                            sio_data_out <= item.rd | item.data[bit_cnt + 3'd1];
                            state        <= bit_low;
                        end
                    end
                end
                gap: begin
                    if (timer_done)
                        state <= idle;                // Strobe held at least a half period
                end
                default: state <= idle;
            endcase
        end
    end

    // ----------------------------------------
    // Payload registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            item <= in_item;
        if (state == bit_low && timer_done)
            rx_byte[bit_cnt] <= sio_data_in;          // Sample with the rising edge
    end

endmodule

`default_nettype wire

// File: project.f
design/board_pkg.sv
design/slow_tick_gen.sv
design/lab_top.sv
design/seg_glyph_encoder.sv
design/tm1638_frame_builder.sv
design/tm1638_sio_shifter.sv
design/board_top.sv
verif/tm1638_assertions.sv
verif/board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the board_top testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log
exe=obj_dir/Vboard_top_tb

verilator --binary --timing --assert --top-module board_top_tb -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$exe" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TB PASSED" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1

// File: verif/board_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

module board_top_tb;

    import board_pkg::*;

    localparam int refresh_timeout = 4000;            // Cycle budget of about two refreshes

    logic                     clk;
    logic                     reset;
    logic [w_board_key - 1:0] key;
    logic [w_sw - 1:0]        sw;
    logic [w_board_led - 1:0] led;
    logic                     sio_clk;
    logic                     sio_stb;
    logic                     sio_data_out;
    logic                     sio_data_oe;
    logic                     sio_data_in;

    integer      seed;
    logic [31:0] rnd;
    key_t        key_pat;                             // Keys the model reports as pressed
    int          stim_errs;
    int          assert_errs;
    int          timeouts;

    // TM1638 model state
    logic        prev_sclk;
    logic        prev_stb;
    logic [2:0]  bit_idx;
    logic [4:0]  byte_cnt;                            // Bytes seen in this group
    logic        reading;
    sio_byte_t   shreg;
    sio_byte_t   grp [0:16];
    sio_byte_t   rd_bytes [0:3];
    int          grp_pos;                             // Group number within a refresh
    int          refresh_cnt;
    int          streak;                              // Refreshes ended with sw[0] low
    int          model_errs;
    logic        have_value;
    count_t      shown_value;
    count_t      prev_value;
    led_t        shown_leds;

    board_top #(.clk_mhz (8), .tick_hz (200000)) dut_i (
        .clk          (clk),
        .reset        (reset),
        .key          (key),
        .sw           (sw),
        .led          (led),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in)
    );

    always #2 clk = ~clk;                             // 4 ns period

    function automatic int check_value(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            return 1;
        end
        return 0;
    endfunction

    // Segment byte back to its hex digit with bit 4 set for an unknown glyph
    function automatic logic [4:0] glyph_value(input sio_byte_t seg);
        case (seg)
            8'h3F:   return 5'h00;
            8'h06:   return 5'h01;
            8'h5B:   return 5'h02;
            8'h4F:   return 5'h03;
            8'h66:   return 5'h04;
            8'h6D:   return 5'h05;
            8'h7D:   return 5'h06;
            8'h07:   return 5'h07;
            8'h7F:   return 5'h08;
            8'h6F:   return 5'h09;
            8'h77:   return 5'h0A;
            8'h7C:   return 5'h0B;
            8'h39:   return 5'h0C;
            8'h5E:   return 5'h0D;
            8'h79:   return 5'h0E;
            8'h71:   return 5'h0F;
            default: return 5'h10;
        endcase
    endfunction

    // ----------------------------------------
    // TM1638 device model
    // ----------------------------------------
    task automatic check_frame();
        count_t     value;
        led_t       leds;
        logic [4:0] nib;
        int         n;
        value = '0;
        for (n = 0; n < 8; n++) begin
            nib = glyph_value(grp[5'(2 * n + 1)]);
            if (nib[4]) begin
                model_errs++;
                $display("Digit %0d shows no hex glyph: %h", n, grp[5'(2 * n + 1)]);
            end
            value = {value[27:0], nib[3:0]};          // Digit 0 is the top nibble
            model_errs += check_value("led_byte", 32'(grp[5'(2 * n + 2)][0]),
                                      32'(grp[5'(2 * n + 2)]));
            leds[3'(n)] = grp[5'(2 * n + 2)][0];
        end
        if (have_value) begin
            if (value < shown_value)
                model_errs += check_value("count_monotonic", shown_value, value);
            if (streak >= 3 && value <= shown_value)  // Whole refresh of ticks between
                model_errs += check_value("count_rises", shown_value + 32'd1, value);
        end
        prev_value  = shown_value;
        shown_value = value;
        shown_leds  = leds;
        have_value  = 1'b1;
    endtask

    task automatic end_group();
        case (grp_pos)
            0: begin
                model_errs += check_value("grp1_len", 1, 32'(byte_cnt));
                model_errs += check_value("grp1_cmd", 32'(cmd_write_auto), 32'(grp[0]));
            end
            1: begin
                model_errs += check_value("grp2_len", 17, 32'(byte_cnt));
                model_errs += check_value("grp2_addr", 32'(cmd_addr_base), 32'(grp[0]));
                if (byte_cnt == 5'd17)
                    check_frame();
            end
            2: begin
                model_errs += check_value("grp3_len", 1, 32'(byte_cnt));
                model_errs += check_value("grp3_cmd", 32'(cmd_display_on), 32'(grp[0]));
            end
            default: begin
                model_errs += check_value("grp4_len", 5, 32'(byte_cnt));
                model_errs += check_value("grp4_cmd", 32'(cmd_read_keys), 32'(grp[0]));
                refresh_cnt++;
                streak++;
            end
        endcase
        grp_pos = (grp_pos + 1) % 4;
    endtask

    // Key i in bit 0 and key i+4 in bit 4 with noise in the other bits
    task automatic load_read_bytes();
        int i;
        for (i = 0; i < 4; i++)
            rd_bytes[2'(i)] = 8'hEE | {3'b000, key_pat[3'(i + 4)], 3'b000, key_pat[3'(i)]};
    endtask

    initial begin : tm1638_model
        sio_data_in = 1'b1;                           // Pull-up level
        prev_sclk   = 1'b1;
        prev_stb    = 1'b1;
        bit_idx     = '0;
        byte_cnt    = '0;
        reading     = 1'b0;
        shreg       = '0;
        grp_pos     = 0;
        refresh_cnt = 0;
        streak      = 0;
        model_errs  = 0;
        have_value  = 1'b0;
        shown_value = '0;
        prev_value  = '0;
        shown_leds  = '0;
        forever begin
            @(negedge clk);
            if (sw[0])
                streak = 0;
            if (!reset) begin
                if (prev_stb && !sio_stb) begin       // Group opens
                    bit_idx  = '0;
                    byte_cnt = '0;
                    reading  = 1'b0;
                end
                if (!sio_stb && prev_sclk && !sio_clk && reading &&
                    byte_cnt >= 5'd1 && byte_cnt <= 5'd4)
                    sio_data_in = rd_bytes[2'(byte_cnt - 5'd1)][bit_idx];
                if (!sio_stb && !prev_sclk && sio_clk) begin
                    shreg[bit_idx] = sio_data_out;    // LSB first
                    bit_idx = bit_idx + 3'd1;
                    if (bit_idx == 3'd0) begin
                        if (byte_cnt < 5'd17)
                            grp[byte_cnt] = shreg;
                        byte_cnt = byte_cnt + 5'd1;
                        if (byte_cnt == 5'd1 && shreg == cmd_read_keys) begin
                            reading = 1'b1;
                            load_read_bytes();
                        end
                    end
                end
                if (!prev_stb && sio_stb) begin       // Group closes
                    end_group();
                    reading     = 1'b0;
                    sio_data_in = 1'b1;
                end
            end
            prev_sclk = sio_clk;
            prev_stb  = sio_stb;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic wait_refreshes(input int n);
        int target;
        int cycles;
        @(posedge clk);
        target = refresh_cnt + n;
        cycles = 0;
        while (timeouts == 0 && refresh_cnt < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > n * refresh_timeout) begin
                timeouts++;
                $display("Timeout: no complete TM1638 refresh within %0d cycles", cycles);
            end
        end
    endtask

    task automatic set_inputs(input logic [w_sw - 1:0] sw_val,
                              input logic [w_board_key - 1:0] key_val, input key_t pat);
        @(negedge clk);
        sw      = sw_val;
        key     = key_val;
        key_pat = pat;
    endtask

    task automatic check_keys();
        led_t merged;
        merged = key_pat | {4'd0, key};               // Board keys ORed with TM1638 keys
        stim_errs += check_value("tm1638_leds", 32'(merged), 32'(shown_leds));
        stim_errs += check_value("board_leds", 32'(merged[w_board_led - 1:0]), 32'(led));
    endtask

    initial begin
        seed        = 26375;
        stim_errs   = 0;
        assert_errs = 0;
        timeouts    = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        key         = '0;
        sw          = '0;
        key_pat     = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        wait_refreshes(5);                            // Free-running count
        for (int p = 0; p < 3; p++) begin
            rnd = $random(seed);
            set_inputs(3'b000, rnd[3:0], rnd[11:4]);
            wait_refreshes(5);                        // Pipeline lags a few refreshes
            check_keys();
        end
        set_inputs(3'b001, key, key_pat);             // Freeze the counter
        wait_refreshes(4);
        stim_errs += check_value("freeze", prev_value, shown_value);
        set_inputs(3'b000, key, key_pat);
        wait_refreshes(5);
        assert_errs = dut_i.assertions_i.fail_cnt;
        $display("Errors: %0d protocol, %0d stimulus, %0d assertion, %0d timeouts",
                 model_errs, stim_errs, assert_errs, timeouts);
        if (model_errs == 0 && stim_errs == 0 && assert_errs == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tm1638_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module tm1638_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 tick,
    input board_pkg::count_t    count,
    input logic                 glyph_valid,
    input logic                 item_valid,
    input logic                 item_ready,
    input board_pkg::sio_item_t item,
    input board_pkg::key_t      key_tm,
    input logic                 sio_clk,
    input logic                 sio_stb,
    input logic                 sio_data_out,
    input logic                 sio_data_oe
);

    logic item_rd;                                    // Byte in the shifter is a read
    int   fail_cnt;                                   // Failed assertions so far

    initial fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (reset)
            item_rd <= 1'b0;
        else if (item_valid && item_ready)
            item_rd <= item.rd;                       // Same handshake as the shifter
    end

    // ----------------------------------------
    // Reset state
    // ----------------------------------------
    reset_pins_idle: assert property (@(posedge clk)
        reset |=> (sio_stb && sio_clk && sio_data_out && !sio_data_oe))
        else begin
            fail_cnt++;
            $error("Serial pins not idle during reset");
        end

    reset_pipe_empty: assert property (@(posedge clk)
        reset |=> (!tick && count == '0 && !glyph_valid && !item_valid && key_tm == '0))
        else begin
            fail_cnt++;
            $error("Pipeline not cleared by reset");
        end

    // ----------------------------------------
    // Serial framing
    // ----------------------------------------
    data_stable_clk_high: assert property (@(posedge clk) disable iff (reset)
        sio_clk |-> $stable(sio_data_out))            // Device samples on the rising edge
        else begin
            fail_cnt++;
            $error("Serial data changed while sio_clk high");
        end

    read_line_released: assert property (@(posedge clk) disable iff (reset)
        ($rose(sio_clk) && item_rd) |-> !sio_data_oe)
        else begin
            fail_cnt++;
            $error("Data line driven during a read bit");
        end

    write_line_driven: assert property (@(posedge clk) disable iff (reset)
        ($rose(sio_clk) && !item_rd) |-> sio_data_oe)
        else begin
            fail_cnt++;
            $error("Data line released during a write bit");
        end

    clk_inside_strobe: assert property (@(posedge clk) disable iff (reset)
        $fell(sio_clk) |-> !sio_stb)                  // Bits only inside a group
        else begin
            fail_cnt++;
            $error("Serial clock toggled with strobe high");
        end

endmodule

bind board_top tm1638_assertions assertions_i (
    .clk          (clk),
    .reset        (reset),
    .tick         (tick),
    .count        (count),
    .glyph_valid  (glyph_valid),
    .item_valid   (item_valid),
    .item_ready   (item_ready),
    .item         (item),
    .key_tm       (key_tm),
    .sio_clk      (sio_clk),
    .sio_stb      (sio_stb),
    .sio_data_out (sio_data_out),
    .sio_data_oe  (sio_data_oe)
);

`default_nettype wire
